/* sim/paging_cases.txt */
# op arg data expect, all hex. RST mode - ula | IOW addr data ula {ear,mic,border}
# MRD addr - ram_addr | MWR addr ram_we ram_addr | SCR - - screen_page | TRB sel - period | PAU - - period
RST 0 00 00
MRD 0123 00 158123
MRD 4567 00 014567
MRD 8ABC 00 008ABC
IOW 7FFD 1C 00
MRD FFFF 00 013FFF
MRD 0000 00 15C000
SCR 0000 00 1
IOW 00FE 15 15
IOW 00FF 07 15
IOW 7FFD 26 15
MRD C000 00 018000
IOW 7FFD 01 15
MRD C000 00 018000
MWR 0100 00 158100
MWR C200 01 018200
RST 1 00 00
IOW 7FFD 07 00
MRD C000 00 000000
RST 2 00 00
IOW 7FFD 10 00
IOW 1FFD 04 00
MRD 0000 00 16C000
MWR 2000 00 16E000
IOW 1FFD 01 00
MWR 3000 01 003000
IOW 1FFD 03 00
MRD C000 00 01C000
IOW 1FFD 05 00
MRD C000 00 00C000
IOW 1FFD 07 00
MRD 4000 00 01C000
TRB 1 00 10
TRB 2 00 08
TRB 3 00 04
TRB 4 00 02
TRB 0 00 20
PAU 0 00 20

/* all.f */
hw/spectrum_pkg.sv
hw/clock_enables.sv
hw/io_ports.sv
hw/memory_pager.sv
hw/spectrum_host.sv
sim/tb_clock.sv
sim/spectrum_host_assert.sv
sim/spectrum_host_tb.sv

/* Bender.yml */
package:
  name: spectrum_host

sources:
  - files:
      - hw/spectrum_pkg.sv
      - hw/clock_enables.sv
      - hw/io_ports.sv
      - hw/memory_pager.sv
      - hw/spectrum_host.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/spectrum_host_assert.sv
      - sim/spectrum_host_tb.sv

/* sim/spectrum_host_tb.sv */
// Testbench for the host core: replays the case file on the CPU bus and checks every response
`timescale 1ns/1ps

module spectrum_host_tb;
	import spectrum_pkg::*;

	logic       clk_sys;
	logic       por_reset;
	logic       case_reset;
	logic       reset;
	mem_mode_t  mode;
	turbo_sel_t turbo_sel;
	logic       pause_toggle;
	cpu_addr_t  addr;
	cpu_data_t  cpu_dout;
	logic       n_mreq;
	logic       n_iorq;
	logic       n_rd;
	logic       n_wr;
	logic       n_m1;
	logic       ce_cpu_p;
	logic       ce_cpu_n;
	logic       ce_psg;
	ram_addr_t  ram_addr;
	logic       ram_we;
	logic       ram_rd;
	logic       screen_page;
	logic [2:0] border;
	logic       ear_out;
	logic       mic_out;

	// Case file contents
	string       op_q[$];
	logic [15:0] arg_q[$];
	logic [7:0]  data_q[$];
	logic [23:0] exp_q[$];
	bit          cases_loaded = 1'b0;
	logic [31:0] lfsr = 32'h70f5_5338;

	// Reference model state
	mem_mode_t  m_mode = MODE_128;
	cpu_data_t  m_7ffd = '0;
	cpu_data_t  m_1ffd = '0;
	logic [4:0] m_ula = '0;   // {ear, mic, border}
	int         m_period = 32;

	assign reset = por_reset | case_reset;

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.reset   (por_reset)
	);

	spectrum_host UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mode         (mode),
		.turbo_sel    (turbo_sel),
		.pause_toggle (pause_toggle),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.n_mreq       (n_mreq),
		.n_iorq       (n_iorq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n),
		.ce_psg       (ce_psg),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd),
		.screen_page  (screen_page),
		.border       (border),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	// ==========================================================
	// Reporting and compare tasks
	// ==========================================================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_ram_addr(input ram_addr_t exp, input ram_addr_t act);
		if (act !== exp)
			fail_run($sformatf("ERR ram_addr expected %h got %h", exp, act));
	endtask

	task automatic check_port(input logic [4:0] exp, input logic [4:0] act);
		if (act !== exp)
			fail_run($sformatf("ERR {ear_out,mic_out,border} expected %h got %h", exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_period(input string name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("ERR %s spacing expected %h got %h", name, exp, act));
	endtask

	task automatic model_agrees(input int idx, input logic [31:0] file_val,
			input logic [31:0] model_val);
		if (file_val !== model_val)
			fail_run($sformatf("case %0d: file expects %h but the paging rules give %h",
				idx, file_val, model_val));
	endtask

	// ==========================================================
	// Reference model
	// ==========================================================
	function automatic ram_addr_t model_ram_addr(input cpu_addr_t a);
		logic [11:0] layout;   // Quarter 0 in the low three bits
		logic [3:0]  bank;
		case (m_1ffd[2:1])
			2'd0:    layout = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    layout = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    layout = {3'd3, 3'd6, 3'd5, 3'd4};
			default: layout = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		if (m_mode == MODE_PLUS3 && m_1ffd[0])
			return {4'd0, layout[a[15:14]*3 +: 3], a[13:0]};
		if (m_mode == MODE_48)
			bank = ROM_48_BANK;
		else if (m_mode == MODE_PLUS3)
			bank = ROM_PLUS3_BASE + 4'(2 * m_1ffd[2]) + 4'(m_7ffd[4]);
		else
			bank = ROM_128_BASE + 4'(m_7ffd[4]);
		case (a[15:14])
			2'd0:    return {ROM_REGION, bank, a[13:0]};
			2'd1:    return {4'd0, SCREEN_PAGE_5, a[13:0]};
			2'd2:    return {4'd0, SCREEN_PAGE_2, a[13:0]};
			default: return {4'd0, m_7ffd[2:0], a[13:0]};
		endcase
	endfunction

	task automatic model_io_write(input cpu_addr_t a, input cpu_data_t d);
		if (!a[0])
			m_ula = d[4:0];
		if (m_mode != MODE_48 && !m_7ffd[5]) begin
			if (!a[15] && !a[1] && (m_mode != MODE_PLUS3 || a[14]))
				m_7ffd = d;
			else if (m_mode == MODE_PLUS3 && a[15:12] == 4'b0001 && !a[1])
				m_1ffd = d;
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic cpu_data_t random_byte();
		logic      feedback;
		cpu_data_t value;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr     = {lfsr[30:0], feedback};
			value    = {value[6:0], feedback};
		end
		return value;
	endfunction

	// ==========================================================
	// Bus and timing helpers
	// ==========================================================
	task automatic bus_release();
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd   = 1'b1;
		n_wr   = 1'b1;
		@(negedge clk_sys);   // Idle cycle between accesses
	endtask

	// 0 ce_cpu_p, 1 ce_cpu_n, 2 ce_psg
	function automatic logic enable_level(input int which);
		case (which)
			0:       return ce_cpu_p;
			1:       return ce_cpu_n;
			default: return ce_psg;
		endcase
	endfunction

	task automatic next_enable(input int which, input int limit, output int waited);
		string name;
		case (which)
			0:       name = "ce_cpu_p";
			1:       name = "ce_cpu_n";
			default: name = "ce_psg";
		endcase
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!enable_level(which) && waited < limit);
		if (!enable_level(which))
			fail_run($sformatf("%s did not appear in time", name));
	endtask

	// First interval may still hold the settle gap
	task automatic measure_cpu_period(input int exp);
		int waited;
		next_enable(0, 400, waited);
		next_enable(0, 400, waited);
		next_enable(0, 64, waited);
		check_period("ce_cpu_p", exp, waited);
		next_enable(1, 64, waited);
		check_period("ce_cpu_n", exp / 2, waited);   // Half a period after ce_cpu_p
	endtask

	task automatic pulse_pause();
		pause_toggle = 1'b1;
		@(negedge clk_sys);
		pause_toggle = 1'b0;
	endtask

	// ==========================================================
	// One case from the file
	// ==========================================================
	task automatic run_case(input int idx);
		string       op;
		cpu_addr_t   a;
		cpu_data_t   d;
		logic [23:0] e;
		cpu_data_t   filler;
		int          waited;
		op = op_q[idx];
		a  = arg_q[idx];
		d  = data_q[idx];
		e  = exp_q[idx];
		if (op == "RST") begin
			mode       = mem_mode_t'(a[1:0]);
			turbo_sel  = TURBO_3M5;
			case_reset = 1'b1;
			repeat (5) @(negedge clk_sys);
			case_reset = 1'b0;
			m_mode     = mode;
			m_7ffd     = '0;
			m_1ffd     = '0;
			m_ula      = '0;
			m_period   = 32;
			@(negedge clk_sys);
			model_agrees(idx, e, m_ula);
			check_port(e[4:0], {ear_out, mic_out, border});
		end else if (op == "IOW") begin
			addr     = a;
			cpu_dout = d;
			n_iorq   = 1'b0;
			n_wr     = 1'b0;
			repeat (2) @(negedge clk_sys);
			bus_release();
			model_io_write(a, d);
			model_agrees(idx, e, m_ula);
			check_port(e[4:0], {ear_out, mic_out, border});
		end else if (op == "MRD") begin
			addr   = a;
			n_mreq = 1'b0;
			n_rd   = 1'b0;
			@(negedge clk_sys);
			model_agrees(idx, e, model_ram_addr(a));
			check_ram_addr(e[20:0], ram_addr);
			check_flag("ram_rd", 1'b1, ram_rd);
			check_flag("ram_we", 1'b0, ram_we);
			bus_release();
		end else if (op == "MWR") begin
			filler   = random_byte();
			addr     = a;
			cpu_dout = filler;
			n_mreq   = 1'b0;
			n_wr     = 1'b0;
			@(negedge clk_sys);
			model_agrees(idx, e, model_ram_addr(a));
			model_agrees(idx, d, (m_mode == MODE_PLUS3 && m_1ffd[0]) || a[15:14] != 2'd0);
			check_ram_addr(e[20:0], ram_addr);
			check_flag("ram_we", d[0], ram_we);
			bus_release();
		end else if (op == "SCR") begin
			model_agrees(idx, e, m_7ffd[3]);
			check_flag("screen_page", e[0], screen_page);
		end else if (op == "TRB") begin
			turbo_sel = turbo_sel_t'(a[2:0]);
			m_period  = 32 >> a[2:0];
			model_agrees(idx, e, m_period);
			measure_cpu_period(e);
		end else if (op == "PAU") begin
			model_agrees(idx, e, m_period);
			pulse_pause();
			repeat (m_period + 2) @(negedge clk_sys);   // Ticks already under way
			repeat (200) begin
				@(negedge clk_sys);
				if (ce_cpu_p || ce_cpu_n || ce_psg)
					fail_run("clock enable seen while paused");
			end
			pulse_pause();
			measure_cpu_period(e);
			next_enable(2, 80, waited);
			next_enable(2, 80, waited);
			check_period("ce_psg", 64, waited);
		end else begin
			fail_run($sformatf("case %0d has an unknown operation %s", idx, op));
		end
	endtask

	// ==========================================================
	// Main sequence and watchdog
	// ==========================================================
	initial begin
		int          fd;
		int          rc;
		string       line;
		string       op;
		logic [15:0] a;
		logic [7:0]  d;
		logic [23:0] e;
		mode         = MODE_128;
		turbo_sel    = TURBO_3M5;
		pause_toggle = 1'b0;
		case_reset   = 1'b0;
		addr         = '0;
		cpu_dout     = '0;
		n_mreq       = 1'b1;
		n_iorq       = 1'b1;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		n_m1         = 1'b1;
		fd = $fopen("sim/paging_cases.txt", "r");
		if (fd == 0)
			fail_run("cannot open the case file sim/paging_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			rc   = $fgets(line, fd);
			if (rc > 0 && line.len() > 2 && line[0] != "#"
					&& $sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
				op_q.push_back(op);
				arg_q.push_back(a);
				data_q.push_back(d);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
		if (op_q.size() == 0)
			fail_run("the case file holds no cases");
		cases_loaded = 1'b1;
		wait (!por_reset);
		@(negedge clk_sys);
		foreach (op_q[i])
			run_case(i);
		repeat (4) @(negedge clk_sys);
		if (UUT.u_host_assert.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			fail_run("a bound assertion failed during the run");
		end
	end

	// Stops at the first failed bound assertion
	initial begin
		wait (UUT.u_host_assert.fail_count != 0);
		fail_run("a bound assertion failed during the run");
	end

	initial begin
		int limit;
		wait (cases_loaded);
		limit = 200 * op_q.size() + 5000;
		repeat (limit) @(posedge clk_sys);
		fail_run("timeout: the cases did not finish in time");
	end

endmodule

/* sim/spectrum_host_assert.sv */
// Concurrent checks on the I/O strobes and the RAM write enable, bound into the host top level
`timescale 1ns/1ps

module spectrum_host_assert (
	input logic clk_sys,
	input logic reset,
	input logic io_wr_pulse,
	input logic io_rd_pulse,
	input logic n_mreq,
	input logic ram_we
);

	int fail_count = 0;   // Watched by the testbench

	// A strobe marks only the first cycle of an access
	wr_pulse_single: assert property (@(posedge clk_sys) disable iff (reset)
		io_wr_pulse |=> !io_wr_pulse)
		else begin
			$error("io_wr_pulse high for two cycles in a row");
			fail_count++;
		end

	pulses_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(io_wr_pulse && io_rd_pulse))
		else begin
			$error("io_wr_pulse and io_rd_pulse high together");
			fail_count++;
		end

	we_needs_mreq: assert property (@(posedge clk_sys) n_mreq |-> !ram_we)
		else begin
			$error("ram_we high without MREQ");
			fail_count++;
		end

endmodule

bind spectrum_host spectrum_host_assert u_host_assert (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.io_wr_pulse (io_wr_pulse),
	.io_rd_pulse (u_io_ports.io_rd_pulse),
	.n_mreq      (n_mreq),
	.ram_we      (ram_we)
);

/* sim/tb_clock.sv */
// Testbench clock and power-on reset source for the host core testbench
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	localparam time HALF_PERIOD  = 4ns;   // 8 ns clock
	localparam int  RESET_CYCLES = 5;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Released on a falling edge like all other stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

/* hw/spectrum_host.sv */
// System-control core of the host board: clock enables, I/O decode and memory paging
`timescale 1ns/1ps

module spectrum_host (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  spectrum_pkg::mem_mode_t  mode,
	input  spectrum_pkg::turbo_sel_t turbo_sel,
	input  logic                     pause_toggle,
	input  spectrum_pkg::cpu_addr_t  addr,
	input  spectrum_pkg::cpu_data_t  cpu_dout,
	input  logic                     n_mreq,
	input  logic                     n_iorq,
	input  logic                     n_rd,
	input  logic                     n_wr,
	input  logic                     n_m1,
	output logic                     ce_cpu_p,
	output logic                     ce_cpu_n,
	output logic                     ce_psg,
	output spectrum_pkg::ram_addr_t  ram_addr,
	output logic                     ram_we,
	output logic                     ram_rd,
	output logic                     screen_page,
	output logic [2:0]               border,
	output logic                     ear_out,
	output logic                     mic_out
);

	logic io_wr_pulse;   // One cycle per port write

	clock_enables u_clock_enables (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.turbo_sel    (turbo_sel),
		.pause_toggle (pause_toggle),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n),
		.ce_psg       (ce_psg)
	);

	io_ports u_io_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.n_iorq      (n_iorq),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.n_m1        (n_m1),
		.io_wr_pulse (io_wr_pulse),
		.io_rd_pulse (),             // No port reads in this core
		.border      (border),
		.ear_out     (ear_out),
		.mic_out     (mic_out)
	);

	memory_pager u_memory_pager (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mode        (mode),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.io_wr_pulse (io_wr_pulse),
		.n_mreq      (n_mreq),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_rd      (ram_rd),
		.screen_page (screen_page)
	);

endmodule

/* hw/memory_pager.sv */
// 128K and +3 memory pager, turning CPU addresses into RAM addresses and strobes
`timescale 1ns/1ps

module memory_pager (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  spectrum_pkg::mem_mode_t mode,
	input  spectrum_pkg::cpu_addr_t addr,
	input  spectrum_pkg::cpu_data_t cpu_dout,
	input  logic                    io_wr_pulse,
	input  logic                    n_mreq,
	input  logic                    n_rd,
	input  logic                    n_wr,
	output spectrum_pkg::ram_addr_t ram_addr,
	output logic                    ram_we,
	output logic                    ram_rd,
	output logic                    screen_page
);
	import spectrum_pkg::*;

	mem_mode_t mode_q;      // Machine mode held from reset
	cpu_data_t page_7ffd;
	cpu_data_t page_1ffd;
	logic      plus3;
	logic      locked;
	logic      sel_7ffd;
	logic      sel_1ffd;
	logic      special;
	logic [1:0] quarter;
	logic [3:0] rom_bank;
	logic [2:0] special_page;

	assign plus3  = (mode_q == MODE_PLUS3);
	assign locked = (mode_q == MODE_48) | page_7ffd[5];

	// Partial decodes as on the real boards
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~plus3);
	assign sel_1ffd = ~addr[1] & addr[12] & ~addr[13] & ~addr[14] & ~addr[15] & plus3;

	// ==========================================================
	// Paging registers
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode_q    <= mode;
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_wr_pulse && !locked) begin
			if (sel_7ffd)
				page_7ffd <= cpu_dout;
			else if (sel_1ffd)
				page_1ffd <= cpu_dout;
		end
	end

	assign special     = plus3 & page_1ffd[0];
	assign quarter     = addr[15:14];
	assign screen_page = page_7ffd[3];

	// ROM bank per mode
	always_comb begin
		case (mode_q)
			MODE_48:    rom_bank = ROM_48_BANK;
			MODE_PLUS3: rom_bank = ROM_PLUS3_BASE + {2'b00, page_1ffd[2], 1'b0}
				+ {3'b000, page_7ffd[4]};
			default:    rom_bank = ROM_128_BASE + {3'b000, page_7ffd[4]};
		endcase
	end

	// All-RAM layouts of 1FFD bits 2..1
	always_comb begin
		case (page_1ffd[2:1])
			2'd0: special_page = {1'b0, quarter};         // 0 1 2 3
			2'd1: special_page = {1'b1, quarter};         // 4 5 6 7
			2'd2: special_page = (quarter == 2'd3) ? 3'd3 : {1'b1, quarter};
			default: begin
				case (quarter)
					2'd0:    special_page = 3'd4;
					2'd1:    special_page = 3'd7;
					2'd2:    special_page = 3'd6;
					default: special_page = 3'd3;
				endcase
			end
		endcase
	end

	// ==========================================================
	// Address translation and strobes
	// ==========================================================
	always_comb begin
		if (special) begin
			ram_addr = {4'd0, special_page, addr[13:0]};
		end else begin
			case (quarter)
				2'd0:    ram_addr = {ROM_REGION, rom_bank, addr[13:0]};
				2'd1:    ram_addr = {4'd0, SCREEN_PAGE_5, addr[13:0]};
				2'd2:    ram_addr = {4'd0, SCREEN_PAGE_2, addr[13:0]};
				default: ram_addr = {4'd0, page_7ffd[2:0], addr[13:0]};
			endcase
		end
	end

	// ROM is write protected unless the +3 all-RAM map is on
	assign ram_we = (special | addr[15] | addr[14]) & ~n_mreq & ~n_wr;
	assign ram_rd = ~n_mreq & ~n_rd;

endmodule

/* hw/io_ports.sv */
// Z80 I/O cycle decoder producing write and read strobes, plus the ULA output port
`timescale 1ns/1ps

module io_ports (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  spectrum_pkg::cpu_addr_t addr,
	input  spectrum_pkg::cpu_data_t cpu_dout,
	input  logic                    n_iorq,
	input  logic                    n_rd,
	input  logic                    n_wr,
	input  logic                    n_m1,
	output logic                    io_wr_pulse,
	output logic                    io_rd_pulse,
	output logic [2:0]              border,
	output logic                    ear_out,
	output logic                    mic_out
);
	import spectrum_pkg::*;

	logic io_wr;
	logic io_rd;
	logic io_wr_d;   // Levels from the previous cycle
	logic io_rd_d;

	// M1 low with IORQ is an interrupt acknowledge, not a port access
	assign io_wr = ~n_iorq & ~n_wr & n_m1;
	assign io_rd = ~n_iorq & ~n_rd & n_m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
			io_rd_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			io_rd_d <= io_rd;
		end
	end

	// First cycle of each access only
	assign io_wr_pulse = io_wr & ~io_wr_d;
	assign io_rd_pulse = io_rd & ~io_rd_d;

	// ==========================================================
	// ULA port, any even address
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (io_wr_pulse && !addr[0]) begin
			border  <= cpu_dout[2:0];
			mic_out <= cpu_dout[3];
			ear_out <= cpu_dout[4];
		end
	end

endmodule

/* hw/clock_enables.sv */
// CPU and PSG clock enables from a free-running counter, with turbo switching and pause
`timescale 1ns/1ps

module clock_enables (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  spectrum_pkg::turbo_sel_t turbo_sel,
	input  logic                     pause_toggle,
	output logic                     ce_cpu_p,
	output logic                     ce_cpu_n,
	output logic                     ce_psg
);
	import spectrum_pkg::*;

	localparam int SETTLE_W = $clog2(TURBO_SETTLE + 1);

	logic [CE_COUNTER_W-1:0] counter;
	logic [TURBO_MASK_W-1:0] turbo_active;   // Mask currently driving the ticks
	logic [TURBO_MASK_W-1:0] turbo_req;
	logic [TURBO_MASK_W-1:0] phase;
	logic                    tick_p;
	logic                    tick_n;
	logic                    cpu_en;
	logic                    pause;
	logic [SETTLE_W-1:0]     settle_cnt;

	assign turbo_req = turbo_mask(turbo_sel);
	assign phase     = counter[TURBO_MASK_W-1:0] & turbo_active;

	// ==========================================================
	// Base counter and raw ticks
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			tick_p  <= 1'b0;
			tick_n  <= 1'b0;
			ce_psg  <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			tick_p  <= (phase == '0);
			// Top set bit of the mask alone, half a period after tick_p
			tick_n  <= (phase == (turbo_active ^ (turbo_active >> 1)));
			ce_psg  <= (counter == '0) & ~pause;   // 1/64 of clk_sys
		end
	end

	// ==========================================================
	// Speed change and pause control
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo_active <= turbo_mask(TURBO_3M5);
			cpu_en       <= 1'b1;
			settle_cnt   <= '0;
			pause        <= 1'b0;
		end else begin
			if (pause_toggle)
				pause <= ~pause;

			// CPU state only moves on its own negative tick
			if (tick_n) begin
				if (turbo_active != turbo_req) begin
					cpu_en       <= 1'b0;
					settle_cnt   <= SETTLE_W'(TURBO_SETTLE);
					turbo_active <= turbo_req;
				end else if (settle_cnt != '0) begin
					settle_cnt <= settle_cnt - 1'b1;
				end else if (!cpu_en) begin
					cpu_en <= ~pause;    // Restart unless paused meanwhile
				end else if (pause) begin
					cpu_en <= 1'b0;
				end
			end
		end
	end

	assign ce_cpu_p = cpu_en & tick_p;
	assign ce_cpu_n = cpu_en & tick_n;

endmodule

/* hw/spectrum_pkg.sv */
// Shared bus types, timing widths and paging constants, imported by every host block
package spectrum_pkg;

	// ==========================================================
	// Widths and timing
	// ==========================================================
	localparam int TURBO_MASK_W = 5;    // Divider mask width
	localparam int CE_COUNTER_W = 6;    // Base counter, 64 cycles per turn
	localparam int TURBO_SETTLE = 3;    // Negative ticks held after a speed change

	// ==========================================================
	// Bus types
	// ==========================================================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [20:0] ram_addr_t;

	// Machine mode, sampled at reset
	typedef enum logic [1:0] {
		MODE_128   = 2'd0,
		MODE_48    = 2'd1,
		MODE_PLUS3 = 2'd2
	} mem_mode_t;

	typedef enum logic [2:0] {
		TURBO_3M5 = 3'd0,
		TURBO_7M  = 3'd1,
		TURBO_14M = 3'd2,
		TURBO_28M = 3'd3,
		TURBO_56M = 3'd4
	} turbo_sel_t;

	// ==========================================================
	// Memory map
	// ==========================================================
	localparam logic [2:0] ROM_REGION     = 3'b101;   // ROM banks sit above all RAM pages
	localparam logic [3:0] ROM_48_BANK    = 4'b1111;
	localparam logic [3:0] ROM_128_BASE   = 4'b0110;  // Plus 7FFD bit 4
	localparam logic [3:0] ROM_PLUS3_BASE = 4'b1000;  // Plus 1FFD bit 2 and 7FFD bit 4

	// Fixed pages behind 4000h and 8000h
	localparam logic [2:0] SCREEN_PAGE_5 = 3'd5;
	localparam logic [2:0] SCREEN_PAGE_2 = 3'd2;

	// Counter bits that must be zero for a CPU tick at the chosen speed
	function automatic logic [TURBO_MASK_W-1:0] turbo_mask(input turbo_sel_t sel);
		logic [TURBO_MASK_W-1:0] mask;
		case (sel)
			TURBO_3M5: mask = 5'b11111;
			TURBO_7M:  mask = 5'b01111;
			TURBO_14M: mask = 5'b00111;
			TURBO_28M: mask = 5'b00011;
			TURBO_56M: mask = 5'b00001;
			default:   mask = 5'b11111;  // Unknown codes fall back to 3.5 MHz
		endcase
		return mask;
	endfunction

endpackage
